//--- rtl/emu_pkg.sv
`default_nettype none

package emu_pkg;

    // Datapath widths
    localparam int data_w = 64;     // Counters, scan words, target registers
    localparam int char_w = 8;      // One console byte

    // Host cycles per emulated target cycle
    localparam int tick_div = 4;
    localparam int phase_w  = $clog2(tick_div);

    // Console FIFO sizing
    localparam int fifo_depth = 8;
    localparam int ptr_w      = $clog2(fifo_depth);
    localparam int level_w    = $clog2(fifo_depth + 1);   // Holds 0..fifo_depth

    // What the target did on a host cycle
    typedef enum logic [1:0] {
        op_step = 2'd0,     // Plain advance, also the no-tick default
        op_emit = 2'd1,     // Advance and push a console byte
        op_trap = 2'd2      // Tick arrived while sitting on the trap point
    } target_op_t;

    // Positions in the flip-flop scan chain
    // Chain order is sdi -> trap -> state -> sdo
    typedef enum logic {
        scan_state = 1'b0,
        scan_trap  = 1'b1
    } scan_sel_t;

endpackage

`default_nettype wire

//--- rtl/emu_ctrl_if.sv
`default_nettype none

interface emu_ctrl_if;

    logic tick;         // One host cycle per emulated cycle
    logic run_mode;     // Target allowed to run
    logic scan_mode;    // Host owns the target state
    logic trig;         // Target sits on its trap point

    modport ctrl (
        input  tick,
        input  trig,
        output run_mode
    );

    modport gate (
        input  run_mode,
        input  scan_mode,
        output tick
    );

    modport tgt (
        input  tick,
        input  scan_mode,
        output trig
    );

endinterface

`default_nettype wire

//--- rtl/emu_clock_gate.sv
`default_nettype none

module emu_clock_gate (
    input  logic       host_clk,
    input  logic       host_rst,
    emu_ctrl_if.gate   ctrl,
    output logic       target_clk,
    output logic       idle
);

    import emu_pkg::*;

    logic [phase_w-1:0] phase;
    logic               phase_en;
    logic               phase_last;

    // Keep going mid-period even if run drops, so no partial target cycle
    assign phase_en   = (ctrl.run_mode && !ctrl.scan_mode) || (phase != '0);
    assign phase_last = (phase == phase_w'(tick_div - 1));

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            phase <= '0;
        end else if (phase_en) begin
            if (phase_last)
                phase <= '0;        // Wrap at the period boundary
            else
                phase <= phase + 1'b1;
        end
    end

    // Pulse on the edge that wraps the phase
    assign ctrl.tick = phase_en && phase_last;

    // Stopped and parked at the boundary
    assign idle = !ctrl.run_mode && (phase == '0);

    // High half then low half; rises together with the wrap
    assign target_clk = (phase < phase_w'(tick_div / 2));

endmodule

`default_nettype wire

//--- rtl/emu_run_ctrl.sv
`default_nettype none

module emu_run_ctrl (
    input  logic                       host_clk,
    input  logic                       host_rst,
    input  logic                       do_pause,
    input  logic                       do_resume,
    input  logic                       count_write,
    input  logic                       step_write,
    input  logic [emu_pkg::data_w-1:0] count_wdata,
    input  logic [emu_pkg::data_w-1:0] step_wdata,
    output logic [emu_pkg::data_w-1:0] count,
    output logic                       step_trig,
    emu_ctrl_if.ctrl                   ctrl
);

    import emu_pkg::*;

    logic [data_w-1:0] step;
    logic [data_w-1:0] step_next;
    logic              run_tick;        // A tick that the target really spends
    logic              pause_held;      // Pause pulse waiting for a tick
    logic              pause_pend;
    logic              stop_req;

    assign run_tick = ctrl.run_mode && ctrl.tick;

    // Emulated cycle counter, host write wins
    always_ff @(posedge host_clk) begin
        if (host_rst)
            count <= '0;
        else if (count_write)
            count <= count_wdata;
        else if (run_tick)
            count <= count + 1'b1;
    end

    // Step countdown, parks at zero
    always_comb begin
        if (step_write)
            step_next = step_wdata;
        else if (step == '0)
            step_next = '0;
        else if (run_tick)
            step_next = step - 1'b1;
        else
            step_next = step;
    end

    always_ff @(posedge host_clk) begin
        if (host_rst)
            step <= '0;
        else
            step <= step_next;
    end

    assign step_trig = (step != '0) && (step_next == '0);    // Expires this cycle

    // Pause pulses can land between ticks
    always_ff @(posedge host_clk) begin
        if (host_rst)
            pause_held <= 1'b0;
        else if (ctrl.tick || do_resume)
            pause_held <= 1'b0;         // Consumed, or cancelled by resume
        else if (do_pause)
            pause_held <= 1'b1;
    end

    assign pause_pend = do_pause || pause_held;
    assign stop_req   = ctrl.trig || step_trig || pause_pend;

    // Stop only on a tick so the gate parks at a boundary
    always_ff @(posedge host_clk) begin
        if (host_rst)
            ctrl.run_mode <= 1'b1;      // Comes out of reset running
        else if (stop_req && ctrl.tick)
            ctrl.run_mode <= 1'b0;
        else if (do_resume)
            ctrl.run_mode <= 1'b1;
    end

endmodule

`default_nettype wire

//--- rtl/emu_target.sv
`default_nettype none

module emu_target (
    input  logic                       host_clk,
    input  logic                       host_rst,
    emu_ctrl_if.tgt                    ctrl,
    input  logic                       ff_scan,
    input  logic                       ff_dir,
    input  logic [emu_pkg::data_w-1:0] ff_sdi,
    output logic [emu_pkg::data_w-1:0] ff_sdo,
    output emu_pkg::target_op_t        op,
    output logic [emu_pkg::char_w-1:0] emit_data
);

    import emu_pkg::*;

    // Scannable registers, indexed by chain position
    logic [data_w-1:0] regs [2];
    logic [data_w-1:0] state_next;
    logic [data_w-1:0] chain_in;
    logic              live_tick;       // Tick not stolen by scan mode
    logic              advance;

    assign state_next = regs[scan_state] + 1'b1;
    assign live_tick  = ctrl.tick && !ctrl.scan_mode;

    // Machine halts on its trap point until the host moves it
    assign ctrl.trig = (regs[scan_state] == regs[scan_trap]);
    assign advance   = live_tick && !ctrl.trig;

    // Recirculate from sdo unless loading from the host
    assign chain_in = ff_dir ? ff_sdi : ff_sdo;

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            regs[scan_state] <= '0;
            regs[scan_trap]  <= '1;     // No trap point after reset
        end else if (ff_scan) begin
            // One word per host cycle
            regs[scan_trap]  <= chain_in;
            regs[scan_state] <= regs[scan_trap];
        end else if (advance) begin
            regs[scan_state] <= state_next;
        end
    end

    assign ff_sdo = regs[scan_state];   // Tail of the chain

    // Classify this cycle for the console path
    always_comb begin
        op = op_step;
        if (live_tick) begin
            if (ctrl.trig)
                op = op_trap;
            else if (state_next[3:0] == 4'd0)
                op = op_emit;           // Crossed a multiple of 16
        end
    end

    assign emit_data = state_next[char_w-1:0];  // Low byte of new state

endmodule

`default_nettype wire

//--- rtl/emu_putchar_fifo.sv
`default_nettype none

module emu_putchar_fifo (
    input  logic                       host_clk,
    input  logic                       host_rst,
    input  emu_pkg::target_op_t        op,
    input  logic [emu_pkg::char_w-1:0] emit_data,
    input  logic                       run_mode,
    output logic                       char_valid,
    output logic [emu_pkg::char_w-1:0] char_data
);

    import emu_pkg::*;

    logic [char_w-1:0]  mem [fifo_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [level_w-1:0] level;
    logic               full;
    logic               empty;
    logic               wr_en;
    logic               rd_en;

    assign full  = (level == level_w'(fifo_depth));
    assign empty = (level == '0);

    assign wr_en = (op == op_emit) && !full;    // Overflow byte is lost
    assign rd_en = !empty && run_mode;          // Drain only while running

    always_ff @(posedge host_clk) begin
        if (wr_en)
            mem[wr_ptr] <= emit_data;
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;        // Both or neither
            endcase
        end
    end

    // Sink output one cycle after the read
    always_ff @(posedge host_clk) begin
        if (host_rst)
            char_valid <= 1'b0;
        else
            char_valid <= rd_en;
    end

    always_ff @(posedge host_clk) begin
        if (rd_en)
            char_data <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

//--- rtl/emu_host.sv
`default_nettype none

module emu_host (
    input  logic                       host_clk,
    input  logic                       host_rst,
    input  logic                       do_pause,
    input  logic                       do_resume,
    input  logic                       scan_mode,
    input  logic                       ff_scan,
    input  logic                       ff_dir,
    input  logic [emu_pkg::data_w-1:0] ff_sdi,
    input  logic                       count_write,
    input  logic [emu_pkg::data_w-1:0] count_wdata,
    input  logic                       step_write,
    input  logic [emu_pkg::data_w-1:0] step_wdata,
    output logic                       target_clk,
    output logic                       run_mode,
    output logic                       idle,
    output logic                       trig,
    output logic                       step_trig,
    output logic [emu_pkg::data_w-1:0] ff_sdo,
    output logic [emu_pkg::data_w-1:0] count,
    output logic                       char_valid,
    output logic [emu_pkg::char_w-1:0] char_data
);

    import emu_pkg::*;

    target_op_t        op;
    logic [char_w-1:0] emit_data;

    emu_ctrl_if ctrl_if ();

    assign ctrl_if.scan_mode = scan_mode;   // Host level straight in
    assign run_mode          = ctrl_if.run_mode;
    assign trig              = ctrl_if.trig;

    emu_clock_gate u_clock_gate (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .ctrl       (ctrl_if.gate),
        .target_clk (target_clk),
        .idle       (idle)
    );

    emu_run_ctrl u_run_ctrl (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .do_pause    (do_pause),
        .do_resume   (do_resume),
        .count_write (count_write),
        .step_write  (step_write),
        .count_wdata (count_wdata),
        .step_wdata  (step_wdata),
        .count       (count),
        .step_trig   (step_trig),
        .ctrl        (ctrl_if.ctrl)
    );

    emu_target u_target (
        .host_clk  (host_clk),
        .host_rst  (host_rst),
        .ctrl      (ctrl_if.tgt),
        .ff_scan   (ff_scan),
        .ff_dir    (ff_dir),
        .ff_sdi    (ff_sdi),
        .ff_sdo    (ff_sdo),
        .op        (op),
        .emit_data (emit_data)
    );

    // Console bytes towards the host sink
    emu_putchar_fifo u_putchar_fifo (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .op         (op),
        .emit_data  (emit_data),
        .run_mode   (ctrl_if.run_mode),
        .char_valid (char_valid),
        .char_data  (char_data)
    );

endmodule

`default_nettype wire

//--- verif/emu_host_tb.sv
`default_nettype none

module emu_host_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import emu_pkg::*;

    // Command codes in the first column of the stim file
    typedef enum logic [3:0] {
        cmd_end    = 4'h0,
        cmd_pause  = 4'h1,
        cmd_resume = 4'h2,
        cmd_run    = 4'h3,
        cmd_halt   = 4'h4,
        cmd_load   = 4'h5,
        cmd_unload = 4'h6,
        cmd_count  = 4'h7,
        cmd_step   = 4'h8,
        cmd_char   = 4'h9,
        cmd_trig   = 4'ha,
        cmd_hold   = 4'hb
    } cmd_t;

    logic              host_clk = 1'b0;
    logic              host_rst;
    logic              do_pause;
    logic              do_resume;
    logic              scan_mode;
    logic              ff_scan;
    logic              ff_dir;
    logic [data_w-1:0] ff_sdi;
    logic              count_write;
    logic [data_w-1:0] count_wdata;
    logic              step_write;
    logic [data_w-1:0] step_wdata;
    logic              target_clk;
    logic              run_mode;
    logic              idle;
    logic              trig;
    logic              step_trig;
    logic [data_w-1:0] ff_sdo;
    logic [data_w-1:0] count;
    logic              char_valid;
    logic [char_w-1:0] char_data;

    logic [data_w-1:0] stim [192];      // Three words per file line
    logic [data_w-1:0] chain_m [2];     // Expected chain indexed by position
    logic [data_w-1:0] count_m;
    logic [data_w-1:0] ticks;           // Target clock rises since last resume
    logic [data_w-1:0] step_pulses;
    logic              prev_tclk;
    logic [char_w-1:0] exp_chars [$];   // Bytes the model says are coming
    logic [char_w-1:0] got_chars [$];   // Bytes seen, waiting for the file
    int                cycles;
    int                limit;

    always #4 host_clk = ~host_clk;     // 8 ns period

    emu_host DUT (.*);

    task automatic end_with_error(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        if (got !== exp)
            end_with_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_char(input string name, input logic [char_w-1:0] got,
                              input logic [char_w-1:0] exp);
        if (got !== exp)
            end_with_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            end_with_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    endtask

    // One emulated target cycle in the model
    task automatic advance_model();
        count_m = count_m + 1'b1;
        ticks   = ticks + 1'b1;
        if (chain_m[scan_state] != chain_m[scan_trap]) begin   // No move on the trap point
            chain_m[scan_state] = chain_m[scan_state] + 1'b1;
            if (chain_m[scan_state][3:0] == 4'h0)
                exp_chars.push_back(chain_m[scan_state][char_w-1:0]);
        end
    endtask

    // Outputs settle before the falling edge and inputs change after this returns
    task automatic next_cycle();
        @(negedge host_clk);
        cycles++;
        if (cycles > limit)
            end_with_error($sformatf("Timeout, no finish within %0d cycles", limit));
        if (target_clk && !prev_tclk)
            advance_model();
        prev_tclk = target_clk;
        if (step_trig)
            step_pulses = step_pulses + 1'b1;
        if (char_valid) begin
            if (exp_chars.size() == 0)
                end_with_error("A console byte came out that the target never emitted");
            else
                check_char("char_data", char_data, exp_chars.pop_front());
            got_chars.push_back(char_data);
        end
    endtask

    task automatic wait_for_stop();
        while (run_mode)
            next_cycle();
        check_bit("idle", idle, 1'b1);      // Parked at a period boundary
        check_bit("target_clk", target_clk, 1'b1);  // High half of the parked period
        check_word("count", count, count_m);
    endtask

    initial begin
        cmd_t              cmd;
        logic [data_w-1:0] op;
        logic [data_w-1:0] exp;
        logic [data_w-1:0] start;
        logic [data_w-1:0] word;
        int                pc;
        host_rst    = 1'b1;
        do_pause    = 1'b0;
        do_resume   = 1'b0;
        scan_mode   = 1'b0;
        ff_scan     = 1'b0;
        ff_dir      = 1'b0;
        ff_sdi      = '0;
        count_write = 1'b0;
        count_wdata = '0;
        step_write  = 1'b0;
        step_wdata  = '0;
        chain_m[scan_state] = '0;
        chain_m[scan_trap]  = '1;         // No trap point out of reset
        count_m     = '0;
        ticks       = '0;
        step_pulses = '0;
        cycles      = 0;
        for (int i = 0; i < 192; i++)
            stim[i] = '0;               // Unused tail reads as end
        $readmemh("verif/emu_host_stim.txt", stim);

        // Budget from all tick counts in the file
        limit = 200;
        for (int i = 0; i < 192; i += 3) begin
            case (cmd_t'(stim[i][3:0]))
                cmd_run:  limit += int'(stim[i + 1]) * tick_div;
                cmd_halt: limit += int'(stim[i + 2]) * tick_div;
                cmd_hold: limit += int'(stim[i + 1]);
                default:  ;
            endcase
        end

        repeat (5) @(posedge host_clk);
        @(negedge host_clk);
        host_rst  = 1'b0;               // Target starts running here
        prev_tclk = target_clk;

        pc  = 0;
        cmd = cmd_t'(stim[0][3:0]);
        while (cmd != cmd_end) begin
            op  = stim[pc + 1];
            exp = stim[pc + 2];
            case (cmd)
                cmd_pause: begin
                    do_pause = 1'b1;
                    next_cycle();
                    do_pause = 1'b0;
                    wait_for_stop();
                end
                cmd_resume: begin
                    ticks       = '0;
                    step_pulses = '0;
                    do_resume   = 1'b1;
                    next_cycle();
                    do_resume   = 1'b0;
                    check_bit("run_mode", run_mode, 1'b1);  // One cycle after the request
                end
                cmd_run: begin
                    start = ticks;
                    while (ticks < start + op)
                        next_cycle();
                end
                cmd_halt: begin
                    wait_for_stop();
                    check_word("ticks", ticks, exp);
                    check_word("step_trig pulses", step_pulses, op);
                end
                cmd_load: begin
                    scan_mode = 1'b1;
                    ff_scan   = 1'b1;
                    ff_dir    = 1'b1;
                    ff_sdi    = op;
                    next_cycle();
                    ff_scan   = 1'b0;
                    ff_dir    = 1'b0;
                    scan_mode = 1'b0;
                    chain_m[scan_state] = chain_m[scan_trap];
                    chain_m[scan_trap]  = op;
                end
                cmd_unload: begin
                    check_word("ff_sdo", ff_sdo, exp);
                    check_word("ff_sdo vs model", ff_sdo, chain_m[scan_state]);
                    if (op != '0) begin
                        scan_mode = 1'b1;
                        ff_scan   = 1'b1;       // ff_dir low so the word wraps round
                        next_cycle();
                        ff_scan   = 1'b0;
                        scan_mode = 1'b0;
                        word                = chain_m[scan_state];
                        chain_m[scan_state] = chain_m[scan_trap];
                        chain_m[scan_trap]  = word;
                    end
                end
                cmd_count: begin
                    count_write = 1'b1;
                    count_wdata = op;
                    count_m     = op;
                    next_cycle();
                    count_write = 1'b0;
                end
                cmd_step: begin
                    step_write = 1'b1;
                    step_wdata = op;
                    next_cycle();
                    step_write = 1'b0;
                end
                cmd_char: begin
                    if (got_chars.size() == 0)
                        end_with_error("Expected a console byte but none has arrived");
                    else
                        check_char("console byte", got_chars.pop_front(), exp[char_w-1:0]);
                end
                cmd_trig: check_bit("trig", trig, exp[0]);
                cmd_hold: begin
                    start = count_m;
                    repeat (int'(op))
                        next_cycle();
                    check_word("count", count, start);      // Frozen while paused
                    check_bit("idle", idle, 1'b1);
                end
                default: end_with_error("Unknown command in the stimulus file");
            endcase
            pc += 3;
            cmd = cmd_t'(stim[pc][3:0]);
        end

        if (exp_chars.size() == 0 && got_chars.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            end_with_error("Console bytes left unchecked at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- verif/emu_host_stim.txt
// Columns: command, operand, expected value, all hex
// 1 pause, 2 resume, 3 run ticks, 4 wait for stop (operand step_trig pulses, expected ticks)
// 5 scan in, 6 check ff_sdo then recirculate if operand set, 7 count, 8 step
// 9 console byte, a trig level, b stay paused for cycles, 0 end
1 0 0                   // Pause right after reset
b 14 0                  // Count frozen while paused
5 100 0                 // Ends up as state
5 fffffffffffffff0 0    // Ends up as trap point
6 1 100
6 1 fffffffffffffff0
6 0 100                 // Chain order again after two recirculations
7 1000 0
2 0 0
3 28 0
1 0 0                   // Count is written value plus rises
9 0 10
9 0 20
8 a 0
2 0 0
4 1 a                   // Step expiry after exactly ten ticks
9 0 30
5 13d 0
5 140 0
2 0 0
4 0 4                   // Three ticks to the trap point, one more to stop
a 0 1
6 0 140
9 0 40
0 0 0

//--- emu_host.f
rtl/emu_pkg.sv
rtl/emu_ctrl_if.sv
rtl/emu_clock_gate.sv
rtl/emu_run_ctrl.sv
rtl/emu_target.sv
rtl/emu_putchar_fifo.sv
rtl/emu_host.sv
verif/emu_host_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the emu_host testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --timescale 1ns/1ps \
    --top-module emu_host_tb -f emu_host.f -o emu_host_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/emu_host_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
